// ==== project.f ====
+incdir+source
source/noc_flit_pkg.sv
source/noc_port_pkg.sv
source/noc_input_fifo.sv
source/noc_output_arbiter.sv
source/noc_router.sv
source/noc_mesh_3x3.sv
sim/noc_checker.sv
sim/tb_noc_mesh.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the NoC testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

rm -rf "$OBJ" "$LOG"

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_noc_mesh \
	-f project.f \
	--Mdir "$OBJ" \
	-o Vtb_noc_mesh
status=$?
if [ $status -ne 0 ]; then
	echo "verilator compile failed with status $status"
	exit 1
fi

"./$OBJ/Vtb_noc_mesh" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Regression failed" "$LOG"; then
	exit 1
fi
if ! grep -q "Regression passed" "$LOG"; then
	echo "simulation ended without a result"
	exit 1
fi
exit 0

// ==== sim/noc_checker.sv ====
`timescale 1ns/1ns
`include "noc_consts.svh"

module noc_checker
	import noc_flit_pkg::*;
(
	input logic                        clk,
	input logic                        rst_n,
	input flit_t                       ej0_flit,
	input flit_t                       ej8_flit,
	input logic [`NOC_NUM_ROUTERS-1:0] rtr_error
);

	// entry layout is source, destination, payload.
	logic [2*`NOC_ADDR_W+`NOC_PAYLOAD_W-1:0] exp_q [$];
	logic [`NOC_NUM_ROUTERS-1:0] err_allow = '0;
	logic err_reported = 1'b0;
	int value_errs = 0;
	int other_errs = 0;

	task automatic fail_value(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		value_errs++;
		$display("[FAIL] %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
	endtask

	task automatic fail_other(input string msg);
		other_errs++;
		$display("error: %s at %0t", msg, $time);
	endtask

	task automatic expect_flit(input logic [`NOC_ADDR_W-1:0] src,
		input logic [`NOC_ADDR_W-1:0] dst, input logic [`NOC_PAYLOAD_W-1:0] payload);
		exp_q.push_back({src, dst, payload});
	endtask

	task automatic allow_errors(input logic [`NOC_NUM_ROUTERS-1:0] mask);
		err_allow = mask;
	endtask

	// ##################################################
	// ejection compare.
	// ##################################################

	task automatic check_ejection(input flit_t f, input logic [`NOC_ADDR_W-1:0] here,
		input string name);
		logic [`NOC_ADDR_W-1:0] dst;
		logic [`NOC_ADDR_W-1:0] src;
		logic [`NOC_PAYLOAD_W-1:0] payload;
		int idx;
		dst = f[`NOC_FLIT_W-2 -: `NOC_ADDR_W];
		src = f[`NOC_PAYLOAD_W +: `NOC_ADDR_W];
		payload = f[`NOC_PAYLOAD_W-1:0];
		if (dst != here) begin
			fail_value({name, ".dest"}, dst, here);
		end
		idx = -1;
		for (int i = 0; i < exp_q.size(); i++) begin
			if (idx < 0 && exp_q[i][`NOC_PAYLOAD_W +: 2*`NOC_ADDR_W] == {src, dst}) begin
				idx = i;
			end
		end
		if (idx < 0) begin
			fail_other($sformatf("%s ejected an unexpected flit 0x%0h", name, f));
		end else begin
			// first entry of the pair, so order within the pair is checked too.
			if (exp_q[idx][`NOC_PAYLOAD_W-1:0] != payload) begin
				fail_value({name, ".payload"}, payload, exp_q[idx][`NOC_PAYLOAD_W-1:0]);
			end
			exp_q.delete(idx);
		end
	endtask

	always @(posedge clk) begin
		if (rst_n) begin
			if (ej0_flit[`NOC_FLIT_W-1]) begin
				check_ejection(ej0_flit, 4'h0, "ej0_flit");
			end
			if (ej8_flit[`NOC_FLIT_W-1]) begin
				check_ejection(ej8_flit, 4'ha, "ej8_flit");
			end
			if (!err_reported && (rtr_error & ~err_allow) != '0) begin
				err_reported = 1'b1;
				fail_value("rtr_error", rtr_error, rtr_error & err_allow);
			end
		end
	end

	// waits until every expected flit has come out.
	task automatic wait_drain(input int limit);
		int n;
		n = 0;
		while (exp_q.size() != 0 && n < limit) begin
			@(posedge clk);
			n++;
		end
		if (exp_q.size() != 0) begin
			fail_other($sformatf("%0d expected flits never ejected", exp_q.size()));
		end
	endtask

	task automatic check_error_flags(input logic [`NOC_NUM_ROUTERS-1:0] exp);
		if (rtr_error != exp) begin
			fail_value("rtr_error", rtr_error, exp);
		end
	endtask

endmodule

// ==== sim/noc_patterns.txt ====
# columns: injection router (0 or 8), destination (hex), payload (hex), stall flag
# stall flag: 0 none, 1 withhold ejection credits for a random time, 2 overflow router 0
0 a 11110001 0
0 a 11110002 0
0 a 11110003 0
8 0 22220001 0
8 0 22220002 0
8 0 22220003 0
0 0 33330001 0
8 a 44440001 0
0 a 11110004 1
8 0 22220004 0
0 a 11110005 0
8 0 22220005 1
0 0 33330002 0
8 a 44440002 1
0 a 11110006 0
8 0 22220006 0
0 a 11110007 1
8 0 22220007 0
0 0 55550000 2

// ==== sim/tb_noc_mesh.sv ====
`timescale 1ns/1ns
`include "noc_consts.svh"

module tb_noc_mesh
	import noc_flit_pkg::*;
;

	logic clk = 1'b0;
	logic rst_n = 1'b0;
	flit_t inj0_flit = '0;
	flit_t inj8_flit = '0;
	logic ej0_credit = 1'b0;
	logic ej8_credit = 1'b0;
	logic inj0_credit;
	logic inj8_credit;
	flit_t ej0_flit;
	flit_t ej8_flit;
	logic [`NOC_NUM_ROUTERS-1:0] rtr_error;

	// top bit of an entry sends the flit without a credit.
	logic [`NOC_FLIT_W:0] q0 [$];
	logic [`NOC_FLIT_W:0] q8 [$];
	int inj0_cnt;
	int inj8_cnt;
	int ej0_pend;
	int ej8_pend;
	int starve0;
	int starve8;
	logic hold0 = 1'b0;
	logic hold8 = 1'b0;
	integer seed = 32'hc0bc;
	logic [`NOC_NUM_ROUTERS-1:0] err_exp = '0;

	noc_mesh_3x3 i_dut (.*);

	noc_checker i_chk (
		.clk       (clk),
		.rst_n     (rst_n),
		.ej0_flit  (ej0_flit),
		.ej8_flit  (ej8_flit),
		.rtr_error (rtr_error)
	);

	initial begin
		forever #5 clk = ~clk;
	end

	initial begin
		#3000000;
		$display("simulation watchdog expired");
		$display("Regression failed");
		$finish;
	end

	// ##################################################
	// injection and ejection credit bookkeeping.
	// ##################################################

	always @(posedge clk) begin
		int c0;
		int c8;
		logic r0;
		logic r8;
		if (!rst_n) begin
			inj0_flit <= '0;
			inj8_flit <= '0;
			ej0_credit <= 1'b0;
			ej8_credit <= 1'b0;
			inj0_cnt = `NOC_FIFO_DEPTH;
			inj8_cnt = `NOC_FIFO_DEPTH;
			ej0_pend = 0;
			ej8_pend = 0;
			starve0 = 0;
			starve8 = 0;
		end else begin
			c0 = inj0_cnt + int'(inj0_credit);
			c8 = inj8_cnt + int'(inj8_credit);
			if (c0 > `NOC_FIFO_DEPTH || c8 > `NOC_FIFO_DEPTH) begin
				i_chk.fail_other("more injection credits returned than flits sent");
			end
			inj0_flit <= '0;
			if (q0.size() > 0 && (c0 > 0 || q0[0][`NOC_FLIT_W])) begin
				inj0_flit <= q0[0][`NOC_FLIT_W-1:0];
				void'(q0.pop_front());
				c0--;
				starve0 = 0;
			end else if (q0.size() > 0) begin
				starve0++;
			end
			inj8_flit <= '0;
			if (q8.size() > 0 && (c8 > 0 || q8[0][`NOC_FLIT_W])) begin
				inj8_flit <= q8[0][`NOC_FLIT_W-1:0];
				void'(q8.pop_front());
				c8--;
				starve8 = 0;
			end else if (q8.size() > 0) begin
				starve8++;
			end
			if (starve0 == 1000 || starve8 == 1000) begin
				i_chk.fail_other("no injection credit returned for 1000 cycles");
			end
			inj0_cnt = c0;
			inj8_cnt = c8;
			// one ejection credit back per cycle unless the port is held.
			r0 = (ej0_pend > 0) && !hold0;
			r8 = (ej8_pend > 0) && !hold8;
			ej0_pend = ej0_pend + int'(ej0_flit[`NOC_FLIT_W-1]) - int'(r0);
			ej8_pend = ej8_pend + int'(ej8_flit[`NOC_FLIT_W-1]) - int'(r8);
			ej0_credit <= r0;
			ej8_credit <= r8;
		end
	end

	// ##################################################
	// stimulus.
	// ##################################################

	task automatic enqueue(input int inj, input logic [3:0] dest, input logic [31:0] payload,
		input logic force_send);
		logic [3:0] src;
		flit_t f;
		int n;
		src = (inj == 0) ? 4'h0 : 4'ha;
		f = {1'b1, dest, src, payload};
		n = 0;
		while (((inj == 0) ? q0.size() : q8.size()) >= 4 && n < 2000) begin
			@(negedge clk);
			n++;
		end
		if (n >= 2000) begin
			i_chk.fail_other("injection queue never drained");
		end
		if (!force_send) begin
			i_chk.expect_flit(src, dest, payload);
		end
		if (inj == 0) begin
			q0.push_back({force_send, f});
		end else begin
			q8.push_back({force_send, f});
		end
	endtask

	task automatic stall_ejection(input logic [3:0] dest);
		int cycles;
		cycles = 4 + (($random(seed) & 32'h7fffffff) % 24);
		if (dest == 4'h0) hold0 = 1'b1;
		else hold8 = 1'b1;
		repeat (cycles) @(negedge clk);
		hold0 = 1'b0;
		hold8 = 1'b0;
	endtask

	// fills router 0 with ej0 held, then sends one flit without a credit.
	task automatic overflow_router0(input logic [31:0] payload);
		int n;
		i_chk.wait_drain(3000);
		// the router 0 local output must hold all its credits before ej0 is held.
		@(negedge clk);
		n = 0;
		while (ej0_pend != 0 && n < 100) begin
			@(negedge clk);
			n++;
		end
		if (ej0_pend != 0) begin
			i_chk.fail_other("ej0 credits still outstanding before the overflow test");
		end
		hold0 = 1'b1;
		for (int k = 0; k < 2 * `NOC_FIFO_DEPTH; k++) begin
			enqueue(0, 4'h0, payload + k, 1'b0);
		end
		n = 0;
		while ((q0.size() != 0 || inj0_cnt != 0) && n < 500) begin
			@(negedge clk);
			n++;
		end
		if (n >= 500) begin
			i_chk.fail_other("router 0 local fifo did not fill");
		end
		repeat (10) @(negedge clk);
		if (inj0_cnt != 0) begin
			i_chk.fail_other("injection credit returned while ej0 was held");
		end
		err_exp = `NOC_NUM_ROUTERS'(1);
		i_chk.allow_errors(err_exp);
		q0.push_back({1'b1, 1'b1, 4'h0, 4'h0, payload + 32'hff});
		n = 0;
		while (!rtr_error[0] && n < 200) begin
			@(negedge clk);
			n++;
		end
		if (!rtr_error[0]) begin
			i_chk.fail_other("router 0 error flag not set after overflow");
		end
		hold0 = 1'b0;
	endtask

	initial begin
		int fd;
		int inj;
		int stall;
		logic [3:0] dest;
		logic [31:0] payload;
		string line;
		repeat (4) @(posedge clk);
		rst_n <= 1'b1;
		repeat (3) begin
			@(negedge clk);
			if (ej0_flit[`NOC_FLIT_W-1]) i_chk.fail_value("ej0_flit.valid", 1, 0);
			if (ej8_flit[`NOC_FLIT_W-1]) i_chk.fail_value("ej8_flit.valid", 1, 0);
			if (rtr_error != '0) i_chk.fail_value("rtr_error", rtr_error, 0);
			if (inj0_credit) i_chk.fail_value("inj0_credit", 1, 0);
		end
		fd = $fopen("sim/noc_patterns.txt", "r");
		if (fd == 0) begin
			i_chk.fail_other("cannot open sim/noc_patterns.txt");
		end else begin
			while (!$feof(fd)) begin
				line = "";
				void'($fgets(line, fd));
				if (line.len() == 0 || line[0] == 8'h23) continue;
				if ($sscanf(line, "%d %h %h %d", inj, dest, payload, stall) != 4) continue;
				@(negedge clk);
				if (stall == 2) begin
					overflow_router0(payload);
				end else begin
					enqueue(inj, dest, payload, 1'b0);
					if (stall == 1) stall_ejection(dest);
				end
			end
			$fclose(fd);
		end
		i_chk.wait_drain(5000);
		repeat (5) @(negedge clk);
		i_chk.check_error_flags(err_exp);
		$display("errors: value=%0d other=%0d", i_chk.value_errs, i_chk.other_errs);
		if (i_chk.value_errs == 0 && i_chk.other_errs == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

// ==== source/noc_consts.svh ====
`ifndef NOC_CONSTS_SVH
`define NOC_CONSTS_SVH

// ##################################################
// mesh geometry.
// ##################################################

`define NOC_DIM 3
`define NOC_NUM_ROUTERS (`NOC_DIM * `NOC_DIM)
`define NOC_NUM_PORTS 5

// ##################################################
// flit layout.
// ##################################################

// address is column bits above row bits.
`define NOC_ADDR_W 4
`define NOC_COORD_W (`NOC_ADDR_W / 2)
`define NOC_PAYLOAD_W 32
// valid, destination, source, payload.
`define NOC_FLIT_W (1 + 2 * `NOC_ADDR_W + `NOC_PAYLOAD_W)

// input buffer depth, also the reset value of every credit counter.
`define NOC_FIFO_DEPTH 4

`endif

// ==== source/noc_flit_pkg.sv ====
`include "noc_consts.svh"

package noc_flit_pkg;

	typedef logic [`NOC_ADDR_W-1:0] noc_addr_t;
	typedef logic [`NOC_FLIT_W-1:0] flit_t;

	function automatic logic flit_valid(flit_t f);
		return f[`NOC_FLIT_W-1];
	endfunction

	function automatic noc_addr_t flit_dest(flit_t f);
		return f[`NOC_FLIT_W-2 -: `NOC_ADDR_W];
	endfunction

	function automatic noc_addr_t flit_src(flit_t f);
		return f[`NOC_PAYLOAD_W +: `NOC_ADDR_W];
	endfunction

	function automatic logic [`NOC_PAYLOAD_W-1:0] flit_payload(flit_t f);
		return f[`NOC_PAYLOAD_W-1:0];
	endfunction

	function automatic flit_t make_flit(noc_addr_t dest, noc_addr_t src,
		logic [`NOC_PAYLOAD_W-1:0] payload);
		return {1'b1, dest, src, payload};
	endfunction

	function automatic logic [`NOC_COORD_W-1:0] addr_col(noc_addr_t a);
		return a[`NOC_ADDR_W-1 -: `NOC_COORD_W];
	endfunction

	function automatic logic [`NOC_COORD_W-1:0] addr_row(noc_addr_t a);
		return a[`NOC_COORD_W-1:0];
	endfunction

endpackage

// ==== source/noc_input_fifo.sv ====
`timescale 1ns/1ns
`include "noc_consts.svh"

module noc_input_fifo
	import noc_flit_pkg::*;
(
	input  logic  clk,
	input  logic  rst_n,
	input  flit_t in_flit,
	input  logic  pop,
	output flit_t head_flit,
	output logic  credit_out,
	output logic  overflow
);

	localparam int depth = `NOC_FIFO_DEPTH;
	localparam int ptr_w = $clog2(depth);
	localparam int cnt_w = $clog2(depth + 1);

	flit_t mem [depth];
	logic [ptr_w-1:0] wr_ptr;
	logic [ptr_w-1:0] rd_ptr;
	logic [cnt_w-1:0] count;
	logic full;
	logic empty;
	logic push;
	logic do_pop;

	assign full = (count == cnt_w'(depth));
	assign empty = (count == '0);
	assign push = flit_valid(in_flit) && !full;
	assign do_pop = pop && !empty;

	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr] <= in_flit;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			credit_out <= 1'b0;
			overflow <= 1'b0;
		end else begin
			if (push) begin
				wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
			end
			count <= count + cnt_w'(push) - cnt_w'(do_pop);
			// one credit back upstream per flit that leaves.
			credit_out <= do_pop;
			// sticky, only reset clears it.
			if (flit_valid(in_flit) && full) begin
				overflow <= 1'b1;
			end
		end
	end

	// an empty fifo shows an invalid flit at its head.
	assign head_flit = empty ? '0 : mem[rd_ptr];

	// the crossbar must only pop a head that holds a flit.
	a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n)
		pop |-> !empty)
		else $error("input fifo popped while empty");

	// pointers meet only when the fifo is empty or full.
	a_count_bound: assert property (@(posedge clk) disable iff (!rst_n)
		count <= cnt_w'(depth) && ((wr_ptr == rd_ptr) == (empty || full)))
		else $error("input fifo occupancy out of step with its pointers");

endmodule

// ==== source/noc_mesh_3x3.sv ====
`timescale 1ns/1ns
`include "noc_consts.svh"

module noc_mesh_3x3
	import noc_flit_pkg::*;
	import noc_port_pkg::*;
(
	input  logic                        clk,
	input  logic                        rst_n,
	input  flit_t                       inj0_flit,
	input  flit_t                       inj8_flit,
	output logic                        inj0_credit,
	output logic                        inj8_credit,
	output flit_t                       ej0_flit,
	output flit_t                       ej8_flit,
	input  logic                        ej0_credit,
	input  logic                        ej8_credit,
	output logic [`NOC_NUM_ROUTERS-1:0] rtr_error
);

	localparam int dim = `NOC_DIM;
	localparam int num_routers = `NOC_NUM_ROUTERS;
	localparam int last = num_routers - 1;

	// router r = row * dim + col.
	flit_t link_in [num_routers][`NOC_NUM_PORTS];
	flit_t link_out [num_routers][`NOC_NUM_PORTS];
	logic [`NOC_NUM_PORTS-1:0] cr_in [num_routers];
	logic [`NOC_NUM_PORTS-1:0] cr_out [num_routers];

	// ##################################################
	// injection and ejection at the two corners.
	// ##################################################

	assign inj0_credit = cr_out[0][PORT_LOCAL];
	assign inj8_credit = cr_out[last][PORT_LOCAL];
	assign ej0_flit = link_out[0][PORT_LOCAL];
	assign ej8_flit = link_out[last][PORT_LOCAL];

	// ##################################################
	// router grid.
	// ##################################################

	for (genvar gy = 0; gy < dim; gy++) begin : g_row
		for (genvar gx = 0; gx < dim; gx++) begin : g_col
			localparam int r = gy * dim + gx;
			localparam noc_addr_t addr = noc_addr_t'((gx << `NOC_COORD_W) | gy);

			// credits on a port come from the neighbor input fed by that output.
			if (gx > 0) begin : g_west
				assign link_in[r][PORT_WEST] = link_out[r-1][PORT_EAST];
				assign cr_in[r][PORT_WEST] = cr_out[r-1][PORT_EAST];
			end else begin : g_west_edge
				assign link_in[r][PORT_WEST] = '0;
				assign cr_in[r][PORT_WEST] = 1'b0;
			end

			if (gx < dim - 1) begin : g_east
				assign link_in[r][PORT_EAST] = link_out[r+1][PORT_WEST];
				assign cr_in[r][PORT_EAST] = cr_out[r+1][PORT_WEST];
			end else begin : g_east_edge
				assign link_in[r][PORT_EAST] = '0;
				assign cr_in[r][PORT_EAST] = 1'b0;
			end

			if (gy > 0) begin : g_north
				assign link_in[r][PORT_NORTH] = link_out[r-dim][PORT_SOUTH];
				assign cr_in[r][PORT_NORTH] = cr_out[r-dim][PORT_SOUTH];
			end else begin : g_north_edge
				assign link_in[r][PORT_NORTH] = '0;
				assign cr_in[r][PORT_NORTH] = 1'b0;
			end

			if (gy < dim - 1) begin : g_south
				assign link_in[r][PORT_SOUTH] = link_out[r+dim][PORT_NORTH];
				assign cr_in[r][PORT_SOUTH] = cr_out[r+dim][PORT_NORTH];
			end else begin : g_south_edge
				assign link_in[r][PORT_SOUTH] = '0;
				assign cr_in[r][PORT_SOUTH] = 1'b0;
			end

			// local ports other than the two corners stay idle.
			if (r == 0) begin : g_local0
				assign link_in[r][PORT_LOCAL] = inj0_flit;
				assign cr_in[r][PORT_LOCAL] = ej0_credit;
			end else if (r == last) begin : g_local8
				assign link_in[r][PORT_LOCAL] = inj8_flit;
				assign cr_in[r][PORT_LOCAL] = ej8_credit;
			end else begin : g_local_off
				assign link_in[r][PORT_LOCAL] = '0;
				assign cr_in[r][PORT_LOCAL] = 1'b0;
			end

			noc_router #(
				.router_addr (addr)
			) rtr (
				.clk        (clk),
				.rst_n      (rst_n),
				.in_flits   (link_in[r]),
				.credit_in  (cr_in[r]),
				.out_flits  (link_out[r]),
				.credit_out (cr_out[r]),
				.error      (rtr_error[r])
			);
		end
	end

endmodule

// ==== source/noc_output_arbiter.sv ====
`timescale 1ns/1ns
`include "noc_consts.svh"

module noc_output_arbiter
	import noc_flit_pkg::*;
	import noc_port_pkg::*;
(
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic [`NOC_NUM_PORTS-1:0] req,
	input  flit_t                     in_flits [`NOC_NUM_PORTS],
	input  logic                      credit_in,
	output logic [`NOC_NUM_PORTS-1:0] grant,
	output flit_t                     out_flit
);

	localparam int np = `NOC_NUM_PORTS;
	localparam int cnt_w = $clog2(`NOC_FIFO_DEPTH + 1);

	arb_state_e state;
	port_e rr_ptr;
	port_e winner;
	logic [cnt_w-1:0] credits;
	logic [`NOC_FLIT_W-2:0] out_body;
	logic send;

	// ##################################################
	// round robin pick.
	// ##################################################

	// a send needs a request and at least one free slot downstream.
	assign send = (credits != '0) && (req != '0);

	// scanning down leaves the requester closest to rr_ptr as winner.
	always_comb begin
		int idx;
		winner = rr_ptr;
		for (int i = np - 1; i >= 0; i--) begin
			idx = (int'(rr_ptr) + i) % np;
			if (req[idx]) begin
				winner = port_e'(idx);
			end
		end
	end

	assign grant = send ? (np'(1) << winner) : '0;

	// ##################################################
	// link register and credit counter.
	// ##################################################

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= ARB_IDLE;
			rr_ptr <= PORT_WEST;
			credits <= cnt_w'(`NOC_FIFO_DEPTH);
		end else begin
			state <= send ? ARB_SEND : ARB_IDLE;
			if (send) begin
				rr_ptr <= port_e'((int'(winner) + 1) % np);
			end
			credits <= credits - cnt_w'(send) + cnt_w'(credit_in);
		end
	end

	always_ff @(posedge clk) begin
		if (send) begin
			out_body <= in_flits[winner][`NOC_FLIT_W-2:0];
		end
	end

	// the state register doubles as the link valid bit.
	assign out_flit = {state == ARB_SEND, out_body};

	a_grant_legal: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot0(grant) && ((grant & ~req) == '0))
		else $error("arbiter grant not one-hot or without request");

	// downstream never returns more credits than it was sent.
	a_credit_bound: assert property (@(posedge clk) disable iff (!rst_n)
		credits <= cnt_w'(`NOC_FIFO_DEPTH))
		else $error("credit counter above fifo depth");

endmodule

// ==== source/noc_port_pkg.sv ====
package noc_port_pkg;

	// router port numbering, the same on inputs and outputs.
	typedef enum logic [2:0] {
		PORT_WEST  = 3'd0,
		PORT_EAST  = 3'd1,
		PORT_NORTH = 3'd2,
		PORT_SOUTH = 3'd3,
		PORT_LOCAL = 3'd4
	} port_e;

	// arb_send means the link register holds a flit this cycle.
	typedef enum logic {
		ARB_IDLE = 1'b0,
		ARB_SEND = 1'b1
	} arb_state_e;

endpackage

// ==== source/noc_router.sv ====
`timescale 1ns/1ns
`include "noc_consts.svh"

module noc_router
	import noc_flit_pkg::*;
	import noc_port_pkg::*;
#(
	parameter noc_addr_t router_addr = '0
) (
	input  logic                      clk,
	input  logic                      rst_n,
	input  flit_t                     in_flits [`NOC_NUM_PORTS],
	input  logic [`NOC_NUM_PORTS-1:0] credit_in,
	output flit_t                     out_flits [`NOC_NUM_PORTS],
	output logic [`NOC_NUM_PORTS-1:0] credit_out,
	output logic                      error
);

	localparam int np = `NOC_NUM_PORTS;

	flit_t heads [np];
	port_e route [np];
	// req and grant are indexed by output, their bits by input.
	logic [np-1:0] req [np];
	logic [np-1:0] grant [np];
	logic [np-1:0] pop;
	logic [np-1:0] overflow;

	// ##################################################
	// xy route computation.
	// ##################################################

	// x first, then y. row numbers grow toward the south.
	function automatic port_e xy_route(noc_addr_t dest);
		port_e dir;
		if (addr_col(dest) > addr_col(router_addr)) begin
			dir = PORT_EAST;
		end else if (addr_col(dest) < addr_col(router_addr)) begin
			dir = PORT_WEST;
		end else if (addr_row(dest) > addr_row(router_addr)) begin
			dir = PORT_SOUTH;
		end else if (addr_row(dest) < addr_row(router_addr)) begin
			dir = PORT_NORTH;
		end else begin
			dir = PORT_LOCAL;
		end
		return dir;
	endfunction

	always_comb begin
		for (int p = 0; p < np; p++) begin
			route[p] = xy_route(flit_dest(heads[p]));
		end
	end

	// ##################################################
	// crossbar requests and pops.
	// ##################################################

	always_comb begin
		for (int o = 0; o < np; o++) begin
			for (int p = 0; p < np; p++) begin
				req[o][p] = flit_valid(heads[p]) && (route[p] == port_e'(o));
			end
		end
	end

	always_comb begin
		pop = '0;
		for (int o = 0; o < np; o++) begin
			pop = pop | grant[o];
		end
	end

	for (genvar p = 0; p < np; p++) begin : g_port
		noc_input_fifo fifo (
			.clk        (clk),
			.rst_n      (rst_n),
			.in_flit    (in_flits[p]),
			.pop        (pop[p]),
			.head_flit  (heads[p]),
			.credit_out (credit_out[p]),
			.overflow   (overflow[p])
		);

		noc_output_arbiter arb (
			.clk       (clk),
			.rst_n     (rst_n),
			.req       (req[p]),
			.in_flits  (heads),
			.credit_in (credit_in[p]),
			.grant     (grant[p]),
			.out_flit  (out_flits[p])
		);
	end

	assign error = |overflow;

endmodule
